// ==== src/bb_ctrl_pkg.sv ====
//************************************************
// Baseboard controller shared definitions
// Register map pages, identification bytes and
// drive LED mode encoding
//************************************************

package bb_ctrl_pkg;

	// Address is page in the upper nibble, offset in the lower
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;
	typedef logic [3:0] page_t;

	// Register map pages
	localparam page_t PAGE_IDENT  = 4'd0;
	localparam page_t PAGE_PRSNT  = 4'd1;
	localparam page_t PAGE_PWR_EN = 4'd2;
	localparam page_t PAGE_PWR_OK = 4'd3;
	localparam page_t PAGE_LED    = 4'd4;
	localparam page_t PAGE_ALERT  = 4'd9;

	// Identification bytes, page 0 offsets 0 and 1
	localparam reg_data_t DEVICE_ID    = 8'h5A;
	localparam reg_data_t CPLD_VERSION = 8'h13;

	// Amber fault LED modes
	typedef enum logic [1:0] {
		LED_OFF  = 2'd0,
		LED_ON   = 2'd1,
		LED_SLOW = 2'd2,
		LED_FAST = 2'd3
	} led_mode_t;

	localparam int DRIVES_PER_BYTE = 8;
	localparam int MODES_PER_BYTE  = 4;

	// Largest drive count the byte pages can hold
	localparam int MAX_DRIVES = 32;

	// One byte of a drive bit vector, zero past the last byte
	function automatic reg_data_t drive_byte(input logic [MAX_DRIVES-1:0] bits,
		input logic [3:0] offset);
		reg_data_t result;
		result = '0;
		if (offset < (MAX_DRIVES / DRIVES_PER_BYTE))
			result = bits[offset * DRIVES_PER_BYTE +: DRIVES_PER_BYTE];
		return result;
	endfunction

endpackage

// ==== src/blink_timebase.sv ====
//************************************************
// Blink timebase
// Clock divider giving fast, slow and heartbeat phases
//************************************************

`timescale 1ns/1ps

module blink_timebase
#(
	parameter int TICK_CYCLES = 8
)
(
	input  logic SYSCLK,
	input  logic RESET_N,
	output logic fast_phase,
	output logic slow_phase,
	output logic heartbeat
);

	localparam int DIV_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [3:0]       tick_cnt;

	assign tick = (div_cnt == DIV_W'(TICK_CYCLES - 1));

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			div_cnt  <= '0;
			tick_cnt <= '0;
		end
		else if (tick)
		begin
			div_cnt  <= '0;
			tick_cnt <= tick_cnt + 4'd1;
		end
		else
		begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

	// Bit 0 flips every tick, bit 2 every 4, bit 3 every 8
	assign fast_phase = tick_cnt[0];
	assign slow_phase = tick_cnt[2];
	assign heartbeat  = tick_cnt[3];

endmodule

// ==== src/host_reg_port.sv ====
//************************************************
// Host register port
// Valid/ready request and response channels onto
// the paged register map, one request in flight
//************************************************

`timescale 1ns/1ps

module host_reg_port
	import bb_ctrl_pkg::*;
#(
	parameter int NUM_DRIVES = 12
)
(
	input  logic       SYSCLK,
	input  logic       RESET_N,
	input  logic       req_valid,
	output logic       req_ready,
	input  reg_addr_t  req_addr,
	input  logic       req_write,
	input  reg_data_t  req_wdata,
	output logic       rsp_valid,
	input  logic       rsp_ready,
	output reg_data_t  rsp_rdata,
	// Register block side
	output logic [3:0] offset,
	output reg_data_t  wdata,
	output logic       pwr_en_wr,
	output logic       led_wr,
	output logic       alert_access,
	input  reg_data_t  prsnt_rdata,
	input  reg_data_t  alert_rdata,
	input  reg_data_t  pwr_en_rdata,
	input  reg_data_t  pwr_ok_rdata,
	input  reg_data_t  led_rdata
);

	page_t     req_page;
	logic      accept;
	reg_data_t rd_mux;

	// A new request waits until the held response is taken
	assign req_ready = ~rsp_valid;
	assign accept    = req_valid & req_ready;

	assign req_page = req_addr[7:4];
	assign offset   = req_addr[3:0];
	assign wdata    = req_wdata;

	//************************************************
	// Strobes, valid only on the accepting clock
	//************************************************
	assign pwr_en_wr    = accept & req_write & (req_page == PAGE_PWR_EN);
	assign led_wr       = accept & req_write & (req_page == PAGE_LED);
	assign alert_access = accept & (req_page == PAGE_ALERT);

	// Read byte for the addressed page
	always_comb
	begin
		rd_mux = '0;
		case (req_page)
			PAGE_IDENT:
			begin
				if (offset == 4'd0)
					rd_mux = DEVICE_ID;
				else if (offset == 4'd1)
					rd_mux = CPLD_VERSION;
			end
			PAGE_PRSNT:  rd_mux = prsnt_rdata;
			PAGE_PWR_EN: rd_mux = pwr_en_rdata;
			PAGE_PWR_OK: rd_mux = pwr_ok_rdata;
			PAGE_LED:    rd_mux = led_rdata;
			// Sampled before the access clears the alert
			PAGE_ALERT:  rd_mux = alert_rdata;
			default:     rd_mux = '0;
		endcase
	end

	//************************************************
	// Response holding register
	//************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			rsp_valid <= 1'b0;
		end
		else if (accept)
		begin
			rsp_valid <= 1'b1;
		end
		else if (rsp_ready)
		begin
			rsp_valid <= 1'b0;
		end
	end

	always_ff @(posedge SYSCLK)
	begin
		if (accept)
			rsp_rdata <= req_write ? '0 : rd_mux;
	end

	// Held response must survive back-pressure unchanged
	rsp_hold_a: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
		else $error("response dropped or changed while rsp_ready low");

	// Drive count only bounds the map, blocks clip their own bytes
	initial
	begin
		if (NUM_DRIVES > MAX_DRIVES)
			$error("drive count exceeds register map");
	end

endmodule

// ==== src/presence_monitor.sv ====
//************************************************
// Drive presence monitor
// Synchronizes presence and latches a change alert
//************************************************

`timescale 1ns/1ps

module presence_monitor
	import bb_ctrl_pkg::*;
#(
	parameter int NUM_DRIVES = 12
)
(
	input  logic                  SYSCLK,
	input  logic                  RESET_N,
	input  logic [NUM_DRIVES-1:0] drv_prsnt,
	input  logic                  alert_access,
	input  logic [3:0]            offset,
	output logic [NUM_DRIVES-1:0] prsnt,
	output reg_data_t             prsnt_rdata,
	output reg_data_t             alert_rdata,
	output logic                  alert
);

	logic [NUM_DRIVES-1:0] prsnt_meta;
	logic [NUM_DRIVES-1:0] prsnt_d;

	// Synchronizer starts at all absent
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			prsnt_meta <= '0;
			prsnt      <= '0;
			prsnt_d    <= '0;
			alert      <= 1'b0;
		end
		else
		begin
			prsnt_meta <= drv_prsnt;
			prsnt      <= prsnt_meta;
			prsnt_d    <= prsnt;
			// Host access beats a change in the same cycle
			if (alert_access)
				alert <= 1'b0;
			else if (prsnt != prsnt_d)
				alert <= 1'b1;
		end
	end

	assign prsnt_rdata = drive_byte(MAX_DRIVES'(prsnt), offset);
	assign alert_rdata = (offset == 4'd0) ? {7'b0, alert} : '0;

endmodule

// ==== src/drive_power_ctrl.sv ====
//************************************************
// Drive power control
// Byte-written enables gated by presence, with
// synchronized power-ok readback
//************************************************

`timescale 1ns/1ps

module drive_power_ctrl
	import bb_ctrl_pkg::*;
#(
	parameter int NUM_DRIVES = 12
)
(
	input  logic                  SYSCLK,
	input  logic                  RESET_N,
	input  logic [3:0]            offset,
	input  reg_data_t             wdata,
	input  logic                  pwr_en_wr,
	input  logic [NUM_DRIVES-1:0] prsnt,
	input  logic [NUM_DRIVES-1:0] drv_pwr_ok,
	output logic [NUM_DRIVES-1:0] drv_pwr_en_l,
	output reg_data_t             pwr_en_rdata,
	output reg_data_t             pwr_ok_rdata
);

	logic [NUM_DRIVES-1:0] pwr_en;
	logic [NUM_DRIVES-1:0] pwr_ok_meta;
	logic [NUM_DRIVES-1:0] pwr_ok;

	// Enable register, one byte per write
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pwr_en <= '0;
		end
		else if (pwr_en_wr)
		begin
			for (int i = 0; i < NUM_DRIVES; i++)
			begin
				if (i / DRIVES_PER_BYTE == offset)
					pwr_en[i] <= wdata[i % DRIVES_PER_BYTE];
			end
		end
	end

	// Power-ok comes from the drive bays, two stages
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pwr_ok_meta <= '0;
			pwr_ok      <= '0;
		end
		else
		begin
			pwr_ok_meta <= drv_pwr_ok;
			pwr_ok      <= pwr_ok_meta;
		end
	end

	// Empty bay never gets power
	assign drv_pwr_en_l = ~(pwr_en & prsnt);

	assign pwr_en_rdata = drive_byte(MAX_DRIVES'(pwr_en), offset);
	assign pwr_ok_rdata = drive_byte(MAX_DRIVES'(pwr_ok), offset);

endmodule

// ==== src/led_pattern_ctrl.sv ====
//************************************************
// Amber fault LED control
// Per-drive mode registers, outputs follow the
// selected blink phase
//************************************************

`timescale 1ns/1ps

module led_pattern_ctrl
	import bb_ctrl_pkg::*;
#(
	parameter int NUM_DRIVES = 12
)
(
	input  logic                  SYSCLK,
	input  logic                  RESET_N,
	input  logic [3:0]            offset,
	input  reg_data_t             wdata,
	input  logic                  led_wr,
	input  logic                  fast_phase,
	input  logic                  slow_phase,
	output logic [NUM_DRIVES-1:0] amber_led,
	output reg_data_t             led_rdata
);

	led_mode_t mode [NUM_DRIVES];

	// Four drive modes per byte, drive 0 in the low bits
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			for (int i = 0; i < NUM_DRIVES; i++)
				mode[i] <= LED_OFF;
		end
		else if (led_wr)
		begin
			for (int i = 0; i < NUM_DRIVES; i++)
			begin
				if (i / MODES_PER_BYTE == offset)
					mode[i] <= led_mode_t'(wdata[2 * (i % MODES_PER_BYTE) +: 2]);
			end
		end
	end

	// Registered LED drive
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			amber_led <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_DRIVES; i++)
			begin
				case (mode[i])
					LED_OFF:  amber_led[i] <= 1'b0;
					LED_ON:   amber_led[i] <= 1'b1;
					LED_SLOW: amber_led[i] <= slow_phase;
					LED_FAST: amber_led[i] <= fast_phase;
				endcase
			end
		end
	end

	always_comb
	begin
		led_rdata = '0;
		for (int i = 0; i < NUM_DRIVES; i++)
		begin
			if (i / MODES_PER_BYTE == offset)
				led_rdata[2 * (i % MODES_PER_BYTE) +: 2] = mode[i];
		end
	end

endmodule

// ==== src/bb_ctrl_top.sv ====
//************************************************
// Baseboard controller top level
// Host register port, drive presence and power,
// amber fault LEDs and heartbeat
//************************************************

`timescale 1ns/1ps

module bb_ctrl_top
	import bb_ctrl_pkg::*;
#(
	parameter int NUM_DRIVES  = 12,
	parameter int TICK_CYCLES = 8
)
(
	input  logic                  SYSCLK,
	input  logic                  RESET_N,
	// Host request channel
	input  logic                  req_valid,
	output logic                  req_ready,
	input  reg_addr_t             req_addr,
	input  logic                  req_write,
	input  reg_data_t             req_wdata,
	// Host response channel
	output logic                  rsp_valid,
	input  logic                  rsp_ready,
	output reg_data_t             rsp_rdata,
	// Drive bays
	input  logic [NUM_DRIVES-1:0] drv_prsnt,
	input  logic [NUM_DRIVES-1:0] drv_pwr_ok,
	output logic [NUM_DRIVES-1:0] drv_pwr_en_l,
	output logic [NUM_DRIVES-1:0] amber_led,
	// Board status
	output logic                  alert,
	output logic                  heartbeat
);

	logic [3:0]            offset;
	reg_data_t             wdata;
	logic                  pwr_en_wr;
	logic                  led_wr;
	logic                  alert_access;
	reg_data_t             prsnt_rdata;
	reg_data_t             alert_rdata;
	reg_data_t             pwr_en_rdata;
	reg_data_t             pwr_ok_rdata;
	reg_data_t             led_rdata;
	logic [NUM_DRIVES-1:0] prsnt;
	logic                  fast_phase;
	logic                  slow_phase;

	//************************************************
	// Input side
	//************************************************
	host_reg_port #(.NUM_DRIVES(NUM_DRIVES)) host_reg_port_inst (
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_addr     (req_addr),
		.req_write    (req_write),
		.req_wdata    (req_wdata),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.rsp_rdata    (rsp_rdata),
		.offset       (offset),
		.wdata        (wdata),
		.pwr_en_wr    (pwr_en_wr),
		.led_wr       (led_wr),
		.alert_access (alert_access),
		.prsnt_rdata  (prsnt_rdata),
		.alert_rdata  (alert_rdata),
		.pwr_en_rdata (pwr_en_rdata),
		.pwr_ok_rdata (pwr_ok_rdata),
		.led_rdata    (led_rdata)
	);

	//************************************************
	// Presence and power
	//************************************************
	presence_monitor #(.NUM_DRIVES(NUM_DRIVES)) presence_monitor_inst (
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.drv_prsnt    (drv_prsnt),
		.alert_access (alert_access),
		.offset       (offset),
		.prsnt        (prsnt),
		.prsnt_rdata  (prsnt_rdata),
		.alert_rdata  (alert_rdata),
		.alert        (alert)
	);

	drive_power_ctrl #(.NUM_DRIVES(NUM_DRIVES)) drive_power_ctrl_inst (
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.offset       (offset),
		.wdata        (wdata),
		.pwr_en_wr    (pwr_en_wr),
		.prsnt        (prsnt),
		.drv_pwr_ok   (drv_pwr_ok),
		.drv_pwr_en_l (drv_pwr_en_l),
		.pwr_en_rdata (pwr_en_rdata),
		.pwr_ok_rdata (pwr_ok_rdata)
	);

	//************************************************
	// LED output side
	//************************************************
	led_pattern_ctrl #(.NUM_DRIVES(NUM_DRIVES)) led_pattern_ctrl_inst (
		.SYSCLK     (SYSCLK),
		.RESET_N    (RESET_N),
		.offset     (offset),
		.wdata      (wdata),
		.led_wr     (led_wr),
		.fast_phase (fast_phase),
		.slow_phase (slow_phase),
		.amber_led  (amber_led),
		.led_rdata  (led_rdata)
	);

	blink_timebase #(.TICK_CYCLES(TICK_CYCLES)) blink_timebase_inst (
		.SYSCLK     (SYSCLK),
		.RESET_N    (RESET_N),
		.fast_phase (fast_phase),
		.slow_phase (slow_phase),
		.heartbeat  (heartbeat)
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
//************************************************
// Testbench clock and reset
// 100 ns clock, reset held low for 16 cycles
//************************************************

`timescale 1ns/1ps

module tb_clock_gen
#(
	parameter int HALF_PERIOD_NS = 50,
	parameter int RESET_CYCLES   = 16
)
(
	output logic SYSCLK,
	output logic RESET_N
);

	initial
	begin
		SYSCLK = 1'b0;
		forever #(HALF_PERIOD_NS) SYSCLK = ~SYSCLK;
	end

	// Release just after an edge, like the other inputs
	initial
	begin
		RESET_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge SYSCLK);
		#1 RESET_N = 1'b1;
	end

endmodule

// ==== verif/tb_bb_ctrl.sv ====
//************************************************
// Baseboard controller testbench
// Table of register accesses with expected data,
// random back-pressure, LED and heartbeat checks
//************************************************

`timescale 1ns/1ps

module tb_bb_ctrl;

	localparam int NUM_DRIVES    = 12;
	localparam int TICK_CYCLES   = 8;
	localparam int MAX_ENTRIES   = 32;
	localparam int WAIT_LIMIT    = 50;
	localparam int SETTLE_CYCLES = 6;

	logic                  SYSCLK;
	logic                  RESET_N;
	logic                  req_valid;
	logic                  req_ready;
	logic [7:0]            req_addr;
	logic                  req_write;
	logic [7:0]            req_wdata;
	logic                  rsp_valid;
	logic                  rsp_ready;
	logic [7:0]            rsp_rdata;
	logic [NUM_DRIVES-1:0] drv_prsnt;
	logic [NUM_DRIVES-1:0] drv_pwr_ok;
	logic [NUM_DRIVES-1:0] drv_pwr_en_l;
	logic [NUM_DRIVES-1:0] amber_led;
	logic                  alert;
	logic                  heartbeat;

	// Stimulus table, one access per entry
	string      tname  [MAX_ENTRIES];
	logic [7:0] taddr  [MAX_ENTRIES];
	logic       twrite [MAX_ENTRIES];
	logic [7:0] twdata [MAX_ENTRIES];
	logic [11:0] tprsnt [MAX_ENTRIES];
	logic [11:0] tok    [MAX_ENTRIES];
	logic [7:0] texp   [MAX_ENTRIES];
	int         num_entries;

	int          error_count;
	int          timeout_count;
	logic [31:0] lcg_state;
	// Expected power-enable register, 4 bytes
	logic [31:0] en_model;

	tb_clock_gen #(.HALF_PERIOD_NS(50), .RESET_CYCLES(16)) tb_clock_gen_inst (
		.SYSCLK  (SYSCLK),
		.RESET_N (RESET_N)
	);

	bb_ctrl_top #(.NUM_DRIVES(NUM_DRIVES), .TICK_CYCLES(TICK_CYCLES)) bb_ctrl_top_inst (
		.SYSCLK       (SYSCLK),
		.RESET_N      (RESET_N),
		.req_valid    (req_valid),
		.req_ready    (req_ready),
		.req_addr     (req_addr),
		.req_write    (req_write),
		.req_wdata    (req_wdata),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.rsp_rdata    (rsp_rdata),
		.drv_prsnt    (drv_prsnt),
		.drv_pwr_ok   (drv_pwr_ok),
		.drv_pwr_en_l (drv_pwr_en_l),
		.amber_led    (amber_led),
		.alert        (alert),
		.heartbeat    (heartbeat)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
		error_count++;
	endtask

	task automatic add_entry(input string name, input logic [7:0] addr, input logic wr,
		input logic [7:0] wd, input logic [11:0] pr, input logic [11:0] ok,
		input logic [7:0] exp);
		tname[num_entries]  = name;
		taddr[num_entries]  = addr;
		twrite[num_entries] = wr;
		twdata[num_entries] = wd;
		tprsnt[num_entries] = pr;
		tok[num_entries]    = ok;
		texp[num_entries]   = exp;
		num_entries++;
	endtask

	//************************************************
	// Stimulus and expected data
	//************************************************
	task automatic build_table();
		add_entry("alert_after_reset",  8'h90, 0, 8'h00, 12'h0F3, 12'h000, 8'h01);
		add_entry("alert_second_read",  8'h90, 0, 8'h00, 12'h0F3, 12'h000, 8'h00);
		add_entry("device_id",          8'h00, 0, 8'h00, 12'h0F3, 12'h000, 8'h5A);
		add_entry("cpld_version",       8'h01, 0, 8'h00, 12'h0F3, 12'h000, 8'h13);
		add_entry("ident_write",        8'h00, 1, 8'hA5, 12'h0F3, 12'h000, 8'h00);
		add_entry("device_id_kept",     8'h00, 0, 8'h00, 12'h0F3, 12'h000, 8'h5A);
		add_entry("unmapped_offset",    8'h0F, 0, 8'h00, 12'h0F3, 12'h000, 8'h00);
		add_entry("unmapped_page",      8'h57, 0, 8'h00, 12'h0F3, 12'h000, 8'h00);
		add_entry("prsnt_low",          8'h10, 0, 8'h00, 12'h0F3, 12'h000, 8'hF3);
		add_entry("prsnt_high",         8'h11, 0, 8'h00, 12'h0F3, 12'h000, 8'h00);
		add_entry("prsnt_changed_low",  8'h10, 0, 8'h00, 12'hA3C, 12'h000, 8'h3C);
		add_entry("prsnt_changed_high", 8'h11, 0, 8'h00, 12'hA3C, 12'h000, 8'h0A);
		add_entry("alert_on_change",    8'h90, 0, 8'h00, 12'hA3C, 12'h000, 8'h01);
		add_entry("alert_cleared",      8'h90, 0, 8'h00, 12'hA3C, 12'h000, 8'h00);
		add_entry("pwr_en_write_low",   8'h20, 1, 8'hFF, 12'hA3C, 12'h000, 8'h00);
		add_entry("pwr_en_write_high",  8'h21, 1, 8'h3F, 12'hA3C, 12'h000, 8'h00);
		add_entry("pwr_en_read_low",    8'h20, 0, 8'h00, 12'hA3C, 12'h000, 8'hFF);
		add_entry("pwr_en_read_high",   8'h21, 0, 8'h00, 12'hA3C, 12'h000, 8'h0F);
		add_entry("drive_removed",      8'h21, 0, 8'h00, 12'h23C, 12'h000, 8'h0F);
		add_entry("prsnt_removed_high", 8'h11, 0, 8'h00, 12'h23C, 12'h000, 8'h02);
		add_entry("alert_on_removal",   8'h90, 0, 8'h00, 12'h23C, 12'h000, 8'h01);
		add_entry("pwr_ok_low",         8'h30, 0, 8'h00, 12'h23C, 12'h5C3, 8'hC3);
		add_entry("pwr_ok_high",        8'h31, 0, 8'h00, 12'h23C, 12'h5C3, 8'h05);
		// Drives 0 to 3 get on, off, slow and fast
		add_entry("led_write_low",      8'h40, 1, 8'hE1, 12'h23C, 12'h5C3, 8'h00);
		add_entry("led_write_high",     8'h42, 1, 8'h1B, 12'h23C, 12'h5C3, 8'h00);
		add_entry("led_read_low",       8'h40, 0, 8'h00, 12'h23C, 12'h5C3, 8'hE1);
		add_entry("led_read_high",      8'h42, 0, 8'h00, 12'h23C, 12'h5C3, 8'h1B);
		add_entry("led_read_unused",    8'h43, 0, 8'h00, 12'h23C, 12'h5C3, 8'h00);
	endtask

	// One table access, entered 1 ns after a rising edge
	task automatic run_entry(input int idx);
		int          hold;
		int          waited;
		int          k;
		logic [31:0] rnd;
		logic [7:0]  held;
		drv_prsnt  = tprsnt[idx];
		drv_pwr_ok = tok[idx];
		repeat (SETTLE_CYCLES) @(posedge SYSCLK);
		#1;
		rnd  = lcg_next();
		hold = (idx == 0) ? 3 : int'(rnd[17:16]);
		req_valid = 1'b1;
		req_addr  = taddr[idx];
		req_write = twrite[idx];
		req_wdata = twdata[idx];
		rsp_ready = (hold == 0);
		waited = 0;
		while (req_ready !== 1'b1 && waited < WAIT_LIMIT)
		begin
			@(posedge SYSCLK);
			#1;
			waited++;
		end
		if (req_ready !== 1'b1)
		begin
			$display("Timeout in %s: request was never accepted", tname[idx]);
			timeout_count++;
			req_valid = 1'b0;
			rsp_ready = 1'b1;
			return;
		end
		@(posedge SYSCLK);
		#1;
		req_valid = 1'b0;
		waited = 0;
		while (rsp_valid !== 1'b1 && waited < WAIT_LIMIT)
		begin
			@(posedge SYSCLK);
			#1;
			waited++;
		end
		if (rsp_valid !== 1'b1)
		begin
			$display("Timeout in %s: no response arrived", tname[idx]);
			timeout_count++;
			rsp_ready = 1'b1;
			return;
		end
		held = rsp_rdata;
		// Host stalls the response
		for (k = 0; k < hold; k++)
		begin
			@(posedge SYSCLK);
			#1;
			if (rsp_valid !== 1'b1)
				report_mismatch({tname[idx], "_held_valid"}, 1, rsp_valid);
			if (rsp_rdata !== held)
				report_mismatch({tname[idx], "_held_data"}, held, rsp_rdata);
			if (req_ready !== 1'b0)
				report_mismatch({tname[idx], "_held_req_ready"}, 0, req_ready);
		end
		rsp_ready = 1'b1;
		@(posedge SYSCLK);
		#1;
		if (held !== texp[idx])
			report_mismatch(tname[idx], texp[idx], held);
		if (twrite[idx] && taddr[idx][7:4] == 4'd2 && taddr[idx][3:0] < 4'd4)
			en_model[taddr[idx][3:0] * 8 +: 8] = twdata[idx];
		// Powered only when enabled and present
		if (drv_pwr_en_l !== ~(en_model[NUM_DRIVES-1:0] & tprsnt[idx]))
			report_mismatch({tname[idx], "_pwr_en_l"},
				~(en_model[NUM_DRIVES-1:0] & tprsnt[idx]), drv_pwr_en_l);
	endtask

	//************************************************
	// LED window and heartbeat
	//************************************************
	task automatic check_leds();
		int         cyc;
		int         slow_toggles;
		int         fast_toggles;
		logic [3:0] prev;
		slow_toggles = 0;
		fast_toggles = 0;
		prev = amber_led[3:0];
		for (cyc = 0; cyc < 64; cyc++)
		begin
			@(posedge SYSCLK);
			#1;
			if (amber_led[0] !== 1'b1)
				report_mismatch("led_on_steady", 1, amber_led[0]);
			if (amber_led[1] !== 1'b0)
				report_mismatch("led_off_steady", 0, amber_led[1]);
			if (amber_led[2] !== prev[2])
				slow_toggles++;
			if (amber_led[3] !== prev[3])
				fast_toggles++;
			prev = amber_led[3:0];
		end
		if (slow_toggles == 0)
			report_mismatch("led_slow_toggles", 1, slow_toggles);
		if (fast_toggles == 0)
			report_mismatch("led_fast_toggles", 1, fast_toggles);
	endtask

	task automatic check_heartbeat();
		int   waited;
		logic start;
		start  = heartbeat;
		waited = 0;
		while (heartbeat === start && waited < 200)
		begin
			@(posedge SYSCLK);
			#1;
			waited++;
		end
		if (heartbeat === start)
		begin
			$display("Timeout: heartbeat did not toggle within 200 cycles");
			timeout_count++;
		end
	endtask

	initial
	begin
		int i;
		int waited;
		req_valid     = 1'b0;
		req_addr      = '0;
		req_write     = 1'b0;
		req_wdata     = '0;
		rsp_ready     = 1'b1;
		drv_prsnt     = 12'h0F3;
		drv_pwr_ok    = '0;
		error_count   = 0;
		timeout_count = 0;
		num_entries   = 0;
		en_model      = '0;
		lcg_state     = 32'hcb966ae4;
		build_table();
		waited = 0;
		while (RESET_N !== 1'b1 && waited < 40)
		begin
			@(posedge SYSCLK);
			waited++;
		end
		if (RESET_N !== 1'b1)
		begin
			$display("Timeout: reset was never released");
			timeout_count++;
		end
		@(posedge SYSCLK);
		#1;
		// Everything idle before the alert can set
		if (req_ready !== 1'b1)
			report_mismatch("reset_req_ready", 1, req_ready);
		if (rsp_valid !== 1'b0)
			report_mismatch("reset_rsp_valid", 0, rsp_valid);
		if (alert !== 1'b0)
			report_mismatch("reset_alert", 0, alert);
		if (drv_pwr_en_l !== '1)
			report_mismatch("reset_pwr_en_l", 12'hFFF, drv_pwr_en_l);
		if (amber_led !== '0)
			report_mismatch("reset_amber_led", 0, amber_led);
		if (heartbeat !== 1'b0)
			report_mismatch("reset_heartbeat", 0, heartbeat);
		for (i = 0; i < num_entries && timeout_count == 0; i++)
			run_entry(i);
		if (timeout_count == 0)
			check_leds();
		if (timeout_count == 0)
			check_heartbeat();
		$display("Summary: %0d table entries, %0d value errors, %0d timeouts",
			num_entries, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== flist.f ====
src/bb_ctrl_pkg.sv
src/blink_timebase.sv
src/host_reg_port.sv
src/presence_monitor.sv
src/drive_power_ctrl.sv
src/led_pattern_ctrl.sv
src/bb_ctrl_top.sv
verif/tb_clock_gen.sv
verif/tb_bb_ctrl.sv
